// ==== rv_pkg.sv ====
package rv_pkg;

    // datapath sizes
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 1 << reg_addr_w;  // x0..x31
    localparam int a0_index   = 10;               // abi name a0
    localparam int cnt_w      = 16;               // retire counter, wraps

    // major opcodes handled by this slice
    localparam logic [6:0] opc_op     = 7'b0110011;  // r-type alu
    localparam logic [6:0] opc_op_imm = 7'b0010011;  // i-type alu
    localparam logic [6:0] opc_lui    = 7'b0110111;

    // funct3 field, shared by op and op-imm
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl     = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7 field of r-type
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub

    // operations the alu knows about
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,   // signed compare
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        alu_pass_b = 4'd8    // lui goes through here
    } alu_op_t;

    // one instruction word, three ways to slice it
    // opcode and rd sit in the same bits in every view
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r_fmt;
        struct packed {
            logic [11:0]           imm12;   // sign bit at [11]
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i_fmt;
        struct packed {
            logic [19:0]           imm20;   // upper immediate
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } u_fmt;
    } instr_t;

endpackage

// ==== rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
    input  rv_pkg::instr_t                 instr,
    output logic [rv_pkg::reg_addr_w-1:0]  rs1,
    output logic [rv_pkg::reg_addr_w-1:0]  rs2,
    output logic [rv_pkg::reg_addr_w-1:0]  rd,
    output logic [rv_pkg::xlen-1:0]        imm,
    output rv_pkg::alu_op_t                alu_op,
    output logic                           use_imm,
    output logic                           reg_write,
    output logic                           illegal_dec
);
    import rv_pkg::*;

    logic legal;  // encoding recognised

    always_comb begin
        // defaults describe a nop that writes nothing
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        imm     = '0;
        alu_op  = alu_add;
        use_imm = 1'b0;
        legal   = 1'b0;

        case (instr.r_fmt.opcode)
            opc_op: begin
                rs1   = instr.r_fmt.rs1;
                rs2   = instr.r_fmt.rs2;
                rd    = instr.r_fmt.rd;
                legal = 1'b1;
                if (instr.r_fmt.funct7 == f7_alt) begin
                    alu_op = alu_sub;
                    legal  = (instr.r_fmt.funct3 == f3_add_sub);  // sra not here
                end else if (instr.r_fmt.funct7 == f7_base) begin
                    case (instr.r_fmt.funct3)
                        f3_add_sub: alu_op = alu_add;
                        f3_sll:     alu_op = alu_sll;
                        f3_slt:     alu_op = alu_slt;
                        f3_xor:     alu_op = alu_xor;
                        f3_srl:     alu_op = alu_srl;
                        f3_or:      alu_op = alu_or;
                        f3_and:     alu_op = alu_and;
                        default:    legal  = 1'b0;  // sltu
                    endcase
                end else begin
                    legal = 1'b0;
                end
            end

            opc_op_imm: begin
                rs1     = instr.i_fmt.rs1;
                rd      = instr.i_fmt.rd;
                imm     = {{(xlen-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
                use_imm = 1'b1;
                legal   = 1'b1;
                case (instr.i_fmt.funct3)
                    f3_add_sub: alu_op = alu_add;
                    f3_slt:     alu_op = alu_slt;
                    f3_xor:     alu_op = alu_xor;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    default:    legal  = 1'b0;  // immediate shifts and sltiu
                endcase
            end

            opc_lui: begin
                rd      = instr.u_fmt.rd;
                imm     = {instr.u_fmt.imm20, {(xlen-20){1'b0}}};  // low 12 bits clear
                use_imm = 1'b1;
                alu_op  = alu_pass_b;
                legal   = 1'b1;
            end

            default: legal = 1'b0;
        endcase
    end

    // x0 is kept at zero here so the regfile never sees such a write
    assign reg_write   = legal && (rd != '0);
    assign illegal_dec = !legal;

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                           clk,
    input  logic [rv_pkg::reg_addr_w-1:0]  rs1,      // read port a
    input  logic [rv_pkg::reg_addr_w-1:0]  rs2,      // read port b
    input  logic [rv_pkg::reg_addr_w-1:0]  wr_addr,
    input  logic                           wr_en,
    input  logic [rv_pkg::xlen-1:0]        wr_data,
    output logic [rv_pkg::xlen-1:0]        rd_data1,
    output logic [rv_pkg::xlen-1:0]        rd_data2,
    output logic [rv_pkg::xlen-1:0]        a0
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [num_regs];  // contents undefined after reset

    // combinational reads, x0 muxed to zero
    assign rd_data1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd_data2 = (rs2 == '0) ? '0 : regs[rs2];

    assign a0 = regs[a0_index];  // observed from outside

    // falling edge write
    // result lands mid cycle so the next issue reads it directly
    always_ff @(negedge clk) begin
        if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // decoder must never let a write reach x0
    a_no_x0_write: assert property (@(negedge clk) wr_en |-> (wr_addr != '0))
        else $error("regfile: write to x0");

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  logic [rv_pkg::xlen-1:0]  op_a,     // rs1 value
    input  logic [rv_pkg::xlen-1:0]  op_b,     // rs2 value
    input  logic [rv_pkg::xlen-1:0]  imm,
    input  logic                     use_imm,
    input  rv_pkg::alu_op_t          alu_op,
    output logic [rv_pkg::xlen-1:0]  result
);
    import rv_pkg::*;

    logic [xlen-1:0]         opnd_b;  // after the imm mux
    logic [$clog2(xlen)-1:0] shamt;
    logic                    lt;

    assign opnd_b = use_imm ? imm : op_b;
    assign shamt  = opnd_b[$clog2(xlen)-1:0];  // low five bits only
    assign lt     = $signed(op_a) < $signed(opnd_b);

    always_comb begin
        case (alu_op)
            alu_add:    result = op_a + opnd_b;
            alu_sub:    result = op_a - opnd_b;
            alu_and:    result = op_a & opnd_b;
            alu_or:     result = op_a | opnd_b;
            alu_xor:    result = op_a ^ opnd_b;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt};  // 1 or 0
            alu_sll:    result = op_a << shamt;
            alu_srl:    result = op_a >> shamt;           // logical
            alu_pass_b: result = opnd_b;                  // lui
            default:    result = '0;                      // unused codes
        endcase
    end

endmodule

// ==== wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           instr_valid,
    input  logic                           reg_write,
    input  logic                           illegal_dec,
    input  logic [rv_pkg::reg_addr_w-1:0]  rd,
    input  logic [rv_pkg::xlen-1:0]        result,
    output logic                           wb_valid,
    output logic                           wr_en,
    output logic                           illegal,       // one cycle pulse
    output logic [rv_pkg::reg_addr_w-1:0]  wb_rd,
    output logic [rv_pkg::xlen-1:0]        wb_data,
    output logic [rv_pkg::cnt_w-1:0]       retire_count
);
    import rv_pkg::*;

    logic accept;       // valid and legal this cycle
    logic reg_write_q;

    assign accept = instr_valid && !illegal_dec;

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid     <= 1'b0;
            illegal      <= 1'b0;
            reg_write_q  <= 1'b0;
            retire_count <= '0;
        end else begin
            wb_valid    <= accept;
            illegal     <= instr_valid && illegal_dec;
            reg_write_q <= reg_write;
            if (accept) begin
                retire_count <= retire_count + 1'b1;  // shows together with wb_valid
            end
        end
    end

    // payload loaded only for retiring instructions
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_rd   <= rd;
            wb_data <= result;
        end
    end

    // rd of x0 retires but writes nothing
    assign wr_en = wb_valid && reg_write_q;

    // control inputs have to be known while running
    a_ctrl_known: assert property (
        @(posedge clk) disable iff (!rst_n)
            !$isunknown(instr_valid) && (!instr_valid || !$isunknown(illegal_dec))
    ) else $error("wb_stage: unknown control input");

endmodule

// ==== exec_core.sv ====
`timescale 1ns/1ps

module exec_core (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           instr_valid,   // qualifies instr
    input  logic [rv_pkg::xlen-1:0]        instr,
    output logic                           wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0]  wb_rd,
    output logic [rv_pkg::xlen-1:0]        wb_data,
    output logic                           illegal,
    output logic [rv_pkg::cnt_w-1:0]       retire_count,
    output logic [rv_pkg::xlen-1:0]        a0
);
    import rv_pkg::*;

    // decode outputs
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
    alu_op_t               alu_op;
    logic                  use_imm;
    logic                  reg_write;
    logic                  illegal_dec;

    // operands and result
    logic [xlen-1:0] rd_data1;
    logic [xlen-1:0] rd_data2;
    logic [xlen-1:0] alu_result;

    logic wr_en;  // write port strobe from stage two

    rv_decoder dec0 (
        .instr       (instr),        // viewed as instr_t inside
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .reg_write   (reg_write),
        .illegal_dec (illegal_dec)
    );

    regfile rf0 (
        .clk      (clk),
        .rs1      (rs1),
        .rs2      (rs2),
        .wr_addr  (wb_rd),     // stage two drives the write port
        .wr_en    (wr_en),
        .wr_data  (wb_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .a0       (a0)
    );

    rv_alu alu0 (
        .op_a    (rd_data1),
        .op_b    (rd_data2),
        .imm     (imm),
        .use_imm (use_imm),
        .alu_op  (alu_op),
        .result  (alu_result)
    );

    wb_stage wb0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .reg_write    (reg_write),
        .illegal_dec  (illegal_dec),
        .rd           (rd),
        .result       (alu_result),
        .wb_valid     (wb_valid),
        .wr_en        (wr_en),
        .illegal      (illegal),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_count (retire_count)
    );

endmodule

// ==== tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core;
    import rv_pkg::*;

    localparam int max_entries    = 64;
    localparam int timeout_cycles = 20;   // per result wait

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid;
    logic [xlen-1:0]       instr;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;
    logic                  illegal;
    logic [cnt_w-1:0]      retire_count;
    logic [xlen-1:0]       a0;

    // stimulus table filled before the run
    logic [31:0] tbl_word [max_entries];
    logic [4:0]  tbl_rd   [max_entries];
    logic [31:0] tbl_exp  [max_entries];
    bit          tbl_ill  [max_entries];
    string       tbl_name [max_entries];
    int          n_entries = 0;
    int          n_legal   = 0;

    logic [31:0] rm [32];                  // reference register model
    logic [31:0] lcg_state = 32'hab2fcf43;
    int          errors = 0;
    int          checks = 0;

    exec_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .illegal      (illegal),
        .retire_count (retire_count),
        .a0           (a0)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rv32i funct3 per mnemonic
    function automatic logic [2:0] funct3_of(string mn);
        if (mn == "sll") return 3'b001;
        if (mn == "slt") return 3'b010;
        if (mn == "xor") return 3'b100;
        if (mn == "srl") return 3'b101;
        if (mn == "or")  return 3'b110;
        if (mn == "and") return 3'b111;
        return 3'b000;                     // add, sub
    endfunction

    function automatic logic [31:0] ref_alu(string mn, logic [31:0] a, logic [31:0] b);
        if (mn == "sub") return a - b;
        if (mn == "and") return a & b;
        if (mn == "or")  return a | b;
        if (mn == "xor") return a ^ b;
        if (mn == "slt") return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        if (mn == "sll") return a << b[4:0];   // shamt from low bits
        if (mn == "srl") return a >> b[4:0];
        return a + b;
    endfunction

    task automatic push_entry(string name, logic [31:0] word, logic [4:0] rd,
                              logic [31:0] exp, bit ill);
        tbl_name[n_entries] = name;
        tbl_word[n_entries] = word;
        tbl_rd[n_entries]   = rd;
        tbl_exp[n_entries]  = exp;
        tbl_ill[n_entries]  = ill;
        n_entries++;
        if (!ill) begin
            n_legal++;
            if (rd != 5'd0) rm[rd] = exp;  // x0 stays zero
        end
    endtask

    task automatic add_r(string mn, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        logic [6:0] f7;
        f7 = (mn == "sub") ? 7'b0100000 : 7'b0000000;
        push_entry($sformatf("%s x%0d,x%0d,x%0d", mn, rd, rs1, rs2),
                   {f7, rs2, rs1, funct3_of(mn), rd, 7'b0110011}, rd,
                   ref_alu(mn, rm[rs1], rm[rs2]), 1'b0);
    endtask

    task automatic add_i(string mn, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        push_entry($sformatf("%si x%0d,x%0d,%h", mn, rd, rs1, imm),
                   {imm, rs1, funct3_of(mn), rd, 7'b0010011}, rd,
                   ref_alu(mn, rm[rs1], {{20{imm[11]}}, imm}), 1'b0);
    endtask

    task automatic add_lui(logic [4:0] rd, logic [19:0] imm);
        push_entry($sformatf("lui x%0d,%h", rd, imm), {imm, rd, 7'b0110111}, rd,
                   {imm, 12'h000}, 1'b0);
    endtask

    task automatic build_table();
        logic [31:0] v;
        logic [31:0] hi;
        logic [4:0]  ra;
        logic [4:0]  rb;
        string       r_ops [8];
        string       i_ops [5];
        r_ops[0] = "add";
        r_ops[1] = "sub";
        r_ops[2] = "and";
        r_ops[3] = "or";
        r_ops[4] = "xor";
        r_ops[5] = "slt";
        r_ops[6] = "sll";
        r_ops[7] = "srl";
        i_ops[0] = "add";
        i_ops[1] = "slt";
        i_ops[2] = "xor";
        i_ops[3] = "or";
        i_ops[4] = "and";
        rm[0] = 32'h0;
        // lui + addi constants with x7 forced positive and x8 negative
        for (int r = 1; r <= 8; r++) begin
            v = lcg_next();
            if (r == 7) v[31] = 1'b0;
            if (r == 8) v[31] = 1'b1;
            hi = v + 32'h800;              // undo sign of low part
            add_lui(r[4:0], hi[31:12]);
            add_i("add", r[4:0], r[4:0], v[11:0]);
        end
        for (int k = 0; k < 8; k++) begin
            v  = lcg_next();
            ra = 5'd1 + v[10:8];
            rb = 5'd1 + v[14:12];
            add_r(r_ops[k], 5'd16 + k[4:0], ra, rb);
        end
        add_r("slt", 5'd24, 5'd8, 5'd7);   // negative below positive
        add_r("slt", 5'd25, 5'd7, 5'd8);
        for (int k = 0; k < 5; k++) begin
            v  = lcg_next();
            ra = 5'd1 + v[22:20];
            add_i(i_ops[k], 5'd26 + k[4:0], ra, v[11:0]);
        end
        add_i("slt", 5'd31, 5'd8, 12'hfff);  // negative vs -1
        // dependent chain issued one per cycle
        add_i("add", 5'd11, 5'd1, lcg_next() >> 20);
        add_r("add", 5'd11, 5'd11, 5'd2);
        add_r("sub", 5'd12, 5'd11, 5'd3);
        add_r("xor", 5'd12, 5'd12, 5'd11);
        add_r("sll", 5'd13, 5'd12, 5'd4);
        add_r("srl", 5'd13, 5'd13, 5'd5);
        add_r("slt", 5'd13, 5'd13, 5'd8);
        add_r("or",  5'd11, 5'd13, 5'd11);
        // x0 write is dropped and a0 gets written
        add_i("add", 5'd0, 5'd1, 12'h123);
        add_r("add", 5'd14, 5'd0, 5'd0);
        add_i("add", 5'd10, 5'd2, lcg_next() >> 20);
        add_r("add", 5'd10, 5'd10, 5'd3);
        // illegal words each followed by a readback of its rd
        push_entry("sra (illegal)", {7'b0100000, 5'd2, 5'd1, 3'b101, 5'd16, 7'b0110011},
                   5'd16, 32'h0, 1'b1);
        add_r("add", 5'd15, 5'd16, 5'd0);
        push_entry("all ones (illegal)", 32'hffff_ffff, 5'd31, 32'h0, 1'b1);
        add_r("add", 5'd15, 5'd31, 5'd0);
        push_entry("slli (illegal)", {7'b0, 5'd3, 5'd1, 3'b001, 5'd16, 7'b0010011},
                   5'd16, 32'h0, 1'b1);
        add_r("add", 5'd15, 5'd16, 5'd0);
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // bounded wait for the next negedge with wb_valid or illegal
    task automatic wait_result(output bit seen, output int waited);
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < timeout_cycles) begin
            @(negedge clk);
            if (wb_valid || illegal) seen = 1'b1;
            else waited++;
        end
    endtask

    task automatic apply_table();
        for (int i = 0; i < n_entries; i++) begin
            @(posedge clk);
            instr       <= tbl_word[i];
            instr_valid <= 1'b1;
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= '0;
    endtask

    task automatic check_results();
        bit seen;
        int waited;
        int exp_wait;
        int err_before;
        for (int i = 0; i < n_entries; i++) begin
            err_before = errors;
            exp_wait   = (i == 0) ? 1 : 0;  // first word is driven one edge after the fork
            wait_result(seen, waited);
            if (!seen) begin
                $display("timeout: entry %0d (%s) gave no result within %0d cycles",
                         i, tbl_name[i], timeout_cycles);
                errors++;
                break;
            end
            if (waited != exp_wait) begin
                $display("entry %0d (%s) came after %0d idle cycles instead of %0d",
                         i, tbl_name[i], waited, exp_wait);
                errors++;
            end
            if (tbl_ill[i]) begin
                check_val("illegal", illegal, 1'b1);
                check_val("wb_valid", wb_valid, 1'b0);
            end else begin
                check_val("wb_valid", wb_valid, 1'b1);
                check_val("illegal", illegal, 1'b0);
                check_val("wb_rd", wb_rd, tbl_rd[i]);
                check_val("wb_data", wb_data, tbl_exp[i]);
            end
            $display("entry %0d %s: %s", i, tbl_name[i],
                     (errors == err_before) ? "ok" : "failed");
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("retire_count", retire_count, 0);   // cleared by reset
        check_val("wb_valid", wb_valid, 1'b0);
        check_val("illegal", illegal, 1'b0);
        $display("reset state: %s", (errors == 0) ? "ok" : "failed");
        fork
            apply_table();
            check_results();
        join
        @(negedge clk);
        check_val("a0", a0, rm[10]);
        check_val("retire_count", retire_count, n_legal);
        $display("end state: a0 %h retire_count %0d", a0, retire_count);
        $display("%0d entries, %0d checks, %0d errors", n_entries, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rv_pkg.sv
rv_decoder.sv
regfile.sv
rv_alu.sv
wb_stage.sv
exec_core.sv
tb_exec_core.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - rv_pkg.sv
  - rv_decoder.sv
  - regfile.sv
  - rv_alu.sv
  - wb_stage.sv
  - exec_core.sv
  - target: test
    files:
      - tb_exec_core.sv
